// ==== compile.f ====
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/decode_if.sv
hdl/inst_decoder.sv
hdl/core_ctrl_fsm.sv
hdl/pc_counter.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/mini_core_top.sv
testbench/mini_core_assertions.sv
testbench/mini_core_tb.sv

// ==== hdl/core_ctrl_fsm.sv ====
`default_nettype none

module core_ctrl_fsm (
	input  logic clk,
	input  logic arst_n,
	input  logic is_ebreak,
	input  logic is_illegal,
	output logic ir_load,
	output logic pc_step,
	output logic wr_strobe,
	output logic commit_valid,
	output logic halted,
	output logic illegal
);
	import core_pkg::*;

	core_state_e state;
	core_state_e state_nxt;
	logic        stop;

	assign stop = is_ebreak || is_illegal;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_FETCH;
			illegal <= 1'b0;
		end else begin
			state <= state_nxt;
			// cause is kept until reset
			if (state == ST_EXEC && is_illegal) begin
				illegal <= 1'b1;
			end
		end
	end

	always_comb begin
		state_nxt    = state;
		ir_load      = 1'b0;
		pc_step      = 1'b0;
		wr_strobe    = 1'b0;
		commit_valid = 1'b0;
		case (state)
			ST_FETCH: begin
				ir_load   = 1'b1;
				state_nxt = ST_EXEC;
			end
			ST_EXEC: begin
				commit_valid = 1'b1;
				wr_strobe    = 1'b1;
				if (stop) begin
					state_nxt = ST_HALT;
				end else begin
					pc_step   = 1'b1;
					state_nxt = ST_FETCH;
				end
			end
			// stuck here until reset
			ST_HALT: state_nxt = ST_HALT;
			default: state_nxt = ST_FETCH;
		endcase
	end

	assign halted = (state == ST_HALT);

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	// data and address words share one width
	typedef logic [31:0] word_t;

	// bit 0 -> rs1 port, bit 1 -> rs2 port
	typedef logic [1:0] read_en_t;

	////////////////////////////////////////
	// control sequencing
	////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXEC,
		ST_HALT
	} core_state_e;

endpackage

`default_nettype wire

// ==== hdl/decode_if.sv ====
`default_nettype none

interface decode_if;
	import rv_isa_pkg::*;
	import core_pkg::*;

	opcode_t   opcode;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	funct3_t   funct3;
	// instruction bit 30
	logic      alt;
	word_t     imm;
	read_en_t  ren;

	modport dec (output opcode, rd, rs1, rs2, funct3, alt, imm, ren);
	modport exe (input opcode, rd, rs1, rs2, funct3, alt, imm);
	modport regs (input rs1, rs2, ren);

endinterface

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`default_nettype none

module exec_unit (
	decode_if.exe           dif,
	input  core_pkg::word_t pc,
	input  core_pkg::word_t rs1_data,
	input  core_pkg::word_t rs2_data,
	output logic            wb_en,
	output core_pkg::word_t wb_data,
	output logic            take_jump,
	output core_pkg::word_t jump_target
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	word_t      op_b;
	word_t      alu_out;
	word_t      jalr_sum;
	logic [4:0] shamt;
	logic       br_taken;

	// second operand, register for R-type else immediate
	assign op_b     = (dif.opcode == OP_R) ? rs2_data : dif.imm;
	assign shamt    = op_b[4:0];
	assign jalr_sum = rs1_data + dif.imm;

	////////////////////////////////////////
	// alu
	////////////////////////////////////////

	always_comb begin
		case (dif.funct3)
			F3_ADD:  alu_out = (dif.opcode == OP_R && dif.alt) ? rs1_data - op_b
			                                                  : rs1_data + op_b;
			F3_SLL:  alu_out = rs1_data << shamt;
			F3_SLT:  alu_out = {31'b0, $signed(rs1_data) < $signed(op_b)};
			F3_SLTU: alu_out = {31'b0, rs1_data < op_b};
			F3_XOR:  alu_out = rs1_data ^ op_b;
			F3_SRL:  alu_out = dif.alt ? word_t'($signed(rs1_data) >>> shamt)
			                           : rs1_data >> shamt;
			F3_OR:   alu_out = rs1_data | op_b;
			F3_AND:  alu_out = rs1_data & op_b;
			default: alu_out = '0;
		endcase
	end

	// branch compare always uses both registers
	always_comb begin
		case (dif.funct3)
			F3_BEQ:  br_taken = (rs1_data == rs2_data);
			F3_BNE:  br_taken = (rs1_data != rs2_data);
			F3_BLT:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
			F3_BGE:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
			F3_BLTU: br_taken = (rs1_data < rs2_data);
			F3_BGEU: br_taken = (rs1_data >= rs2_data);
			default: br_taken = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// writeback and next pc
	////////////////////////////////////////

	always_comb begin
		wb_en       = 1'b1;
		wb_data     = alu_out;
		take_jump   = 1'b0;
		jump_target = pc + dif.imm;
		case (dif.opcode)
			OP_R, OP_I: wb_data = alu_out;
			OP_LUI:     wb_data = dif.imm;
			OP_AUIPC:   wb_data = pc + dif.imm;
			OP_JAL: begin
				wb_data   = pc + 32'd4;
				take_jump = 1'b1;
			end
			OP_JALR: begin
				wb_data     = pc + 32'd4;
				take_jump   = 1'b1;
				jump_target = {jalr_sum[31:1], 1'b0};
			end
			OP_BRANCH: begin
				wb_en     = 1'b0;
				take_jump = br_taken;
			end
			// ebreak and unknown opcodes write nothing
			default: wb_en = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               ir_load,
	input  rv_isa_pkg::inst_t  imem_data,
	decode_if.dec              dif,
	output logic               is_ebreak,
	output logic               is_illegal
);
	import rv_isa_pkg::*;
	import core_pkg::*;

	inst_t   ir;
	opcode_t op;
	word_t   imm_i;
	word_t   imm_b;
	word_t   imm_u;
	word_t   imm_j;
	logic    op_known;

	// instruction register, loaded on the fetch edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ir <= '0;
		end else if (ir_load) begin
			ir <= imem_data;
		end
	end

	assign op         = ir[6:0];
	assign dif.opcode = op;
	assign dif.rd     = ir[11:7];
	assign dif.funct3 = ir[14:12];
	assign dif.rs1    = ir[19:15];
	assign dif.rs2    = ir[24:20];
	assign dif.alt    = ir[30];

	////////////////////////////////////////
	// immediates
	////////////////////////////////////////

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

	// imm select, read enables and opcode check
	always_comb begin
		dif.imm  = '0;
		dif.ren  = 2'b00;
		op_known = 1'b1;
		case (op)
			OP_R: dif.ren = 2'b11;
			OP_I: begin
				dif.imm = imm_i;
				dif.ren = 2'b01;
			end
			OP_JALR: begin
				dif.imm = imm_i;
				dif.ren = 2'b01;
			end
			OP_BRANCH: begin
				dif.imm = imm_b;
				dif.ren = 2'b11;
			end
			OP_LUI, OP_AUIPC: dif.imm = imm_u;
			OP_JAL: dif.imm = imm_j;
			// anything in SYSTEM but ebreak is rejected
			OP_SYSTEM: op_known = (ir == EBREAK_WORD);
			default: op_known = 1'b0;
		endcase
	end

	assign is_ebreak  = (ir == EBREAK_WORD);
	assign is_illegal = !op_known;

endmodule

`default_nettype wire

// ==== hdl/mini_core_top.sv ====
`default_nettype none

module mini_core_top #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  rv_isa_pkg::inst_t     imem_data,
	output core_pkg::word_t       imem_addr,
	output logic                  commit_valid,
	output core_pkg::word_t       commit_pc,
	output rv_isa_pkg::reg_addr_t commit_rd,
	output logic                  commit_wen,
	output core_pkg::word_t       commit_data,
	output logic                  halted,
	output logic                  illegal
);
	import core_pkg::*;

	logic  ir_load;
	logic  pc_step;
	logic  wr_strobe;
	logic  is_ebreak;
	logic  is_illegal;
	logic  take_jump;
	logic  wb_en;
	word_t jump_target;
	word_t wb_data;
	word_t rs1_data;
	word_t rs2_data;
	word_t pc;

	decode_if dif ();

	core_ctrl_fsm ctrl_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.is_ebreak    (is_ebreak),
		.is_illegal   (is_illegal),
		.ir_load      (ir_load),
		.pc_step      (pc_step),
		.wr_strobe    (wr_strobe),
		.commit_valid (commit_valid),
		.halted       (halted),
		.illegal      (illegal)
	);

	pc_counter #(
		.RESET_PC (RESET_PC)
	) pc_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.pc_step     (pc_step),
		.take_jump   (take_jump),
		.jump_target (jump_target),
		.pc          (pc)
	);

	inst_decoder dec_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.ir_load    (ir_load),
		.imem_data  (imem_data),
		.dif        (dif),
		.is_ebreak  (is_ebreak),
		.is_illegal (is_illegal)
	);

	reg_file rf_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_strobe (wr_strobe),
		.wb_en     (wb_en),
		.wb_rd     (dif.rd),
		.wb_data   (wb_data),
		.dif       (dif),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data)
	);

	exec_unit exu_i (
		.dif         (dif),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.wb_en       (wb_en),
		.wb_data     (wb_data),
		.take_jump   (take_jump),
		.jump_target (jump_target)
	);

	// fetch and commit ports
	assign imem_addr   = pc;
	assign commit_pc   = pc;
	assign commit_rd   = dif.rd;
	assign commit_wen  = wb_en;
	assign commit_data = wb_data;

endmodule

`default_nettype wire

// ==== hdl/pc_counter.sv ====
`default_nettype none

module pc_counter #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            pc_step,
	input  logic            take_jump,
	input  core_pkg::word_t jump_target,
	output core_pkg::word_t pc
);

	// step on the execute edge only
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (pc_step) begin
			if (take_jump) begin
				pc <= jump_target;
			end else begin
				pc <= pc + 32'd4;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 wr_strobe,
	input  logic                 wb_en,
	input  rv_isa_pkg::reg_addr_t wb_rd,
	input  core_pkg::word_t      wb_data,
	decode_if.regs               dif,
	output core_pkg::word_t      rs1_data,
	output core_pkg::word_t      rs2_data
);
	import core_pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_strobe && wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// gated reads, x0 and disabled ports give zero
	assign rs1_data = (dif.ren[0] && dif.rs1 != '0) ? regs[dif.rs1] : '0;
	assign rs2_data = (dif.ren[1] && dif.rs2 != '0) ? regs[dif.rs2] : '0;

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	////////////////////////////////////////
	// field types
	////////////////////////////////////////

	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] inst_t;

	// major opcodes of the supported classes
	localparam opcode_t OP_R      = 7'b0110011;
	localparam opcode_t OP_I      = 7'b0010011;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	// only SYSTEM word that is accepted
	localparam inst_t EBREAK_WORD = 32'h0010_0073;

	// alu minor ops, bit 30 picks sub / sra
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SRL  = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// branch compare kinds
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mini_core_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vmini_core_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

// ==== testbench/mini_core_assertions.sv ====
`default_nettype none

module mini_core_assertions (
	input logic clk,
	input logic arst_n,
	input logic commit_valid,
	input logic halted,
	input logic illegal
);

	// one commit per two-cycle instruction
	commit_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		commit_valid |=> !commit_valid)
		else $error("commit_valid high in two consecutive cycles");

	// halt is sticky until reset
	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted)
		else $error("halted dropped without a reset");

	halt_no_commit: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> !commit_valid)
		else $error("commit_valid high while halted");

	illegal_halts: assert property (@(posedge clk) disable iff (!arst_n)
		illegal |-> halted)
		else $error("illegal high without halted");

endmodule

bind mini_core_top mini_core_assertions mini_core_assertions_i (
	.clk          (clk),
	.arst_n       (arst_n),
	.commit_valid (commit_valid),
	.halted       (halted),
	.illegal      (illegal)
);

`default_nettype wire

// ==== testbench/mini_core_tb.sv ====
`default_nettype none

module mini_core_tb;
	import rv_isa_pkg::*;

	localparam int CYCLE_LIMIT = 600;

	logic        clk = 1'b0;
	logic        arst_n;
	logic [31:0] imem_data;
	logic [31:0] imem_addr;
	logic        commit_valid;
	logic [31:0] commit_pc;
	logic [4:0]  commit_rd;
	logic        commit_wen;
	logic [31:0] commit_data;
	logic        halted;
	logic        illegal;

	// instruction ROM and the expected commit stream
	logic [31:0] rom [0:63];
	logic [31:0] exp_pc [$];
	logic [4:0]  exp_rd [$];
	logic        exp_wen [$];
	logic [31:0] exp_data [$];
	int          commit_cyc [$];
	logic [31:0] pc_model;

	int seed;
	int errors;
	int checks;
	int tests_run;
	int cycle_count = 0;

	always #20 clk = ~clk;

	assign imem_data = rom[imem_addr[7:2]];

	mini_core_top mini_core_top_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.imem_data    (imem_data),
		.imem_addr    (imem_addr),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_rd    (commit_rd),
		.commit_wen   (commit_wen),
		.commit_data  (commit_data),
		.halted       (halted),
		.illegal      (illegal)
	);

	// hard stop for a core that never halts
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// instruction encoders
	////////////////////////////////////////

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	////////////////////////////////////////
	// program build and run
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
		end
	endtask

	// reloads the ROM and holds the core in reset
	task automatic begin_program();
		// opcode 0 everywhere so a stray fetch halts as illegal
		for (int i = 0; i < 64; i++) begin
			rom[i[5:0]] = {i[24:0], 7'b0000000};
		end
		@(posedge clk);
		arst_n <= 1'b0;
		exp_pc.delete();
		exp_rd.delete();
		exp_wen.delete();
		exp_data.delete();
		pc_model = 32'd0;
	endtask

	task automatic emit(input logic [31:0] word, input logic wen, input logic [31:0] data,
			input logic [31:0] next_pc);
		rom[pc_model[7:2]] = word;
		exp_pc.push_back(pc_model);
		exp_rd.push_back(word[11:7]);
		exp_wen.push_back(wen);
		exp_data.push_back(data);
		pc_model = next_pc;
	endtask

	task automatic emit_seq(input logic [31:0] word, input logic wen, input logic [31:0] data);
		emit(word, wen, data, pc_model + 32'd4);
	endtask

	// taken branches skip one word
	task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic taken);
		emit(enc_b(13'd8, rs2, rs1, f3), 1'b0, 32'd0,
			taken ? pc_model + 32'd8 : pc_model + 32'd4);
	endtask

	task automatic run_program();
		int   cyc;
		int   idx;
		logic done;
		commit_cyc.delete();
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_value("reset commit_valid", 32'(commit_valid), 32'd0);
		check_value("reset halted", 32'(halted), 32'd0);
		check_value("reset illegal", 32'(illegal), 32'd0);
		check_value("reset imem_addr", imem_addr, 32'd0);
		@(posedge clk);
		arst_n <= 1'b1;
		cyc = 0;
		idx = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			cyc++;
			if (commit_valid) begin
				if (idx < exp_pc.size()) begin
					check_value("commit_pc", commit_pc, exp_pc[idx]);
					check_value("commit_rd", 32'(commit_rd), 32'(exp_rd[idx]));
					check_value("commit_wen", 32'(commit_wen), 32'(exp_wen[idx]));
					if (exp_wen[idx]) begin
						check_value("commit_data", commit_data, exp_data[idx]);
					end
				end else begin
					errors++;
					$display("unexpected commit at pc %h past the end of the program", commit_pc);
				end
				commit_cyc.push_back(cyc);
				idx++;
			end
			if (halted) begin
				done = 1'b1;
			end else if (cyc > 2 * exp_pc.size() + 8) begin
				errors++;
				$display("core did not halt within %0d cycles at t=%0t", cyc, $time);
				done = 1'b1;
			end
		end
		check_value("commit count", 32'(idx), 32'(exp_pc.size()));
		// pc holds on the halting instruction
		check_value("halted imem_addr", imem_addr, exp_pc[exp_pc.size() - 1]);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("test %s finished with %0d errors", name, errors - errors_before);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_alu_ops();
		logic [31:0] r;
		logic [19:0] ua;
		logic [11:0] ia;
		logic [11:0] ib;
		logic [11:0] ic;
		logic [4:0]  sh;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		int          e0;
		e0 = errors;
		r = $random(seed);
		ua = r[31:12];
		ia = r[11:0];
		r = $random(seed);
		ib = r[11:0];
		ic = r[23:12];
		sh = r[28:24];
		v1 = {ua, 12'b0} + sext12(ia);
		v2 = sext12(ib);
		v3 = sext12(ic);
		begin_program();
		emit_seq(enc_u(ua, 5'd1, OP_LUI), 1'b1, {ua, 12'b0});
		emit_seq(enc_i(ia, 5'd1, F3_ADD, 5'd1, OP_I), 1'b1, v1);
		emit_seq(enc_i(ib, 5'd0, F3_ADD, 5'd2, OP_I), 1'b1, v2);
		// register forms
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), 1'b1, v1 + v2);
		emit_seq(enc_r(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4), 1'b1, v1 - v2);
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_SLL, 5'd5), 1'b1, v1 << v2[4:0]);
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_SRL, 5'd6), 1'b1, v1 >> v2[4:0]);
		emit_seq(enc_r(7'h20, 5'd2, 5'd1, F3_SRL, 5'd7), 1'b1, $signed(v1) >>> v2[4:0]);
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_SLT, 5'd8), 1'b1,
			{31'b0, $signed(v1) < $signed(v2)});
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd9), 1'b1, {31'b0, v1 < v2});
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd10), 1'b1, v1 ^ v2);
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd11), 1'b1, v1 | v2);
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd12), 1'b1, v1 & v2);
		// immediate forms
		emit_seq(enc_i(ic, 5'd1, F3_SLT, 5'd13, OP_I), 1'b1,
			{31'b0, $signed(v1) < $signed(v3)});
		emit_seq(enc_i(ic, 5'd1, F3_SLTU, 5'd14, OP_I), 1'b1, {31'b0, v1 < v3});
		emit_seq(enc_i(ic, 5'd1, F3_XOR, 5'd15, OP_I), 1'b1, v1 ^ v3);
		emit_seq(enc_i(ic, 5'd1, F3_OR, 5'd16, OP_I), 1'b1, v1 | v3);
		emit_seq(enc_i(ic, 5'd1, F3_AND, 5'd17, OP_I), 1'b1, v1 & v3);
		emit_seq(enc_i({7'h00, sh}, 5'd1, F3_SLL, 5'd18, OP_I), 1'b1, v1 << sh);
		emit_seq(enc_i({7'h00, sh}, 5'd1, F3_SRL, 5'd19, OP_I), 1'b1, v1 >> sh);
		emit_seq(enc_i({7'h20, sh}, 5'd1, F3_SRL, 5'd20, OP_I), 1'b1, $signed(v1) >>> sh);
		// x0 write is reported but discarded
		emit_seq(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd0), 1'b1, v1 + v2);
		emit_seq(enc_r(7'h00, 5'd1, 5'd0, F3_ADD, 5'd21), 1'b1, v1);
		emit_seq(enc_r(7'h00, 5'd0, 5'd1, F3_ADD, 5'd22), 1'b1, v1);
		emit_seq(enc_i(12'd0, 5'd0, F3_ADD, 5'd23, OP_I), 1'b1, 32'd0);
		emit_seq(EBREAK_WORD, 1'b0, 32'd0);
		run_program();
		report_test("alu_ops", e0);
	endtask

	task automatic test_upper_jumps();
		logic [31:0] r;
		logic [19:0] u1;
		logic [19:0] u2;
		logic [31:0] base;
		int          e0;
		e0 = errors;
		r = $random(seed);
		u1 = r[19:0];
		r = $random(seed);
		u2 = r[31:12];
		begin_program();
		emit_seq(enc_u(u1, 5'd1, OP_LUI), 1'b1, {u1, 12'b0});
		emit_seq(enc_u(u2, 5'd2, OP_AUIPC), 1'b1, pc_model + {u2, 12'b0});
		emit(enc_j(21'd12, 5'd3), 1'b1, pc_model + 32'd4, pc_model + 32'd12);
		emit_seq(enc_u(u2, 5'd4, OP_AUIPC), 1'b1, pc_model + {u2, 12'b0});
		// odd base so the jalr target has bit 0 to clear
		base = pc_model + 32'd21;
		emit_seq(enc_i(base[11:0], 5'd0, F3_ADD, 5'd5, OP_I), 1'b1, base);
		emit(enc_i(12'd4, 5'd5, 3'b000, 5'd6, OP_JALR), 1'b1, pc_model + 32'd4,
			(base + 32'd4) & ~32'd1);
		emit_seq(EBREAK_WORD, 1'b0, 32'd0);
		run_program();
		report_test("upper_jumps", e0);
	endtask

	task automatic test_branches();
		logic [31:0] r;
		logic [11:0] ineg;
		logic [11:0] ipos;
		int          e0;
		e0 = errors;
		r = $random(seed);
		ineg = {1'b1, r[10:0]};
		ipos = {1'b0, r[26:16] | 11'd1};
		begin_program();
		// x1 negative, x2 small positive, x3 copy of x1
		emit_seq(enc_i(ineg, 5'd0, F3_ADD, 5'd1, OP_I), 1'b1, sext12(ineg));
		emit_seq(enc_i(ipos, 5'd0, F3_ADD, 5'd2, OP_I), 1'b1, sext12(ipos));
		emit_seq(enc_i(12'd0, 5'd1, F3_ADD, 5'd3, OP_I), 1'b1, sext12(ineg));
		emit_branch(F3_BEQ, 5'd1, 5'd3, 1'b1);
		emit_branch(F3_BEQ, 5'd1, 5'd2, 1'b0);
		emit_branch(F3_BNE, 5'd1, 5'd2, 1'b1);
		emit_branch(F3_BNE, 5'd1, 5'd3, 1'b0);
		emit_branch(F3_BLT, 5'd1, 5'd2, 1'b1);
		emit_branch(F3_BLT, 5'd2, 5'd1, 1'b0);
		emit_branch(F3_BGE, 5'd2, 5'd1, 1'b1);
		emit_branch(F3_BGE, 5'd1, 5'd2, 1'b0);
		emit_branch(F3_BLTU, 5'd2, 5'd1, 1'b1);
		emit_branch(F3_BLTU, 5'd1, 5'd2, 1'b0);
		emit_branch(F3_BGEU, 5'd1, 5'd2, 1'b1);
		emit_branch(F3_BGEU, 5'd2, 5'd1, 1'b0);
		emit_seq(EBREAK_WORD, 1'b0, 32'd0);
		run_program();
		report_test("branches", e0);
	endtask

	task automatic test_ebreak();
		int e0;
		e0 = errors;
		begin_program();
		emit_seq(enc_i(12'd7, 5'd0, F3_ADD, 5'd1, OP_I), 1'b1, 32'd7);
		emit_seq(EBREAK_WORD, 1'b0, 32'd0);
		run_program();
		check_value("halted", 32'(halted), 32'd1);
		check_value("illegal", 32'(illegal), 32'd0);
		repeat (2) begin
			@(negedge clk);
			check_value("commit_valid after halt", 32'(commit_valid), 32'd0);
		end
		report_test("ebreak", e0);
	endtask

	task automatic check_illegal_halt(input logic [31:0] word);
		begin_program();
		emit_seq(enc_i(12'd3, 5'd0, F3_ADD, 5'd1, OP_I), 1'b1, 32'd3);
		emit_seq(word, 1'b0, 32'd0);
		run_program();
		check_value("halted", 32'(halted), 32'd1);
		check_value("illegal", 32'(illegal), 32'd1);
	endtask

	task automatic test_illegal();
		int e0;
		e0 = errors;
		// a load and a SYSTEM word other than ebreak
		check_illegal_halt(32'h0040_a103);
		check_illegal_halt(32'h0000_0073);
		report_test("illegal", e0);
	endtask

	task automatic test_commit_timing();
		int e0;
		e0 = errors;
		begin_program();
		for (int i = 1; i <= 6; i++) begin
			emit_seq(enc_i(i[11:0], 5'd0, F3_ADD, i[4:0], OP_I), 1'b1, 32'(i));
		end
		emit_seq(EBREAK_WORD, 1'b0, 32'd0);
		run_program();
		if (commit_cyc.size() == 0) begin
			errors++;
			$display("no commit was seen after reset");
		end else begin
			check_value("first commit cycle", 32'(commit_cyc[0]), 32'd2);
			for (int k = 1; k < commit_cyc.size(); k++) begin
				check_value("commit spacing", 32'(commit_cyc[k] - commit_cyc[k - 1]), 32'd2);
			end
		end
		report_test("commit_timing", e0);
	endtask

	initial begin
		arst_n = 1'b0;
		seed = 59109;
		errors = 0;
		checks = 0;
		tests_run = 0;
		test_alu_ops();
		test_upper_jumps();
		test_branches();
		test_ebreak();
		test_illegal();
		test_commit_timing();
		$display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
